// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= mono_shifter_tb
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f files.f
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
logic/shifter_pkg.sv
logic/beam_if.sv
logic/beam_timing.sv
logic/word_fetch.sv
logic/pixel_shifter.sv
logic/shifter_regs.sv
logic/mono_shifter_top.sv
tests/mono_shifter_checker.sv
tests/mono_shifter_tb.sv

// ==== logic/beam_if.sv ====
/*
 * beam interface from the timing generator
 * carries line number, sync, frame end and window strobes
 * to the fetch and serializer stages
 */

`timescale 1ns/1ps

interface beam_if;
	import shifter_pkg::*;

	// current line
	beam_t vcnt;

	// far behind the visible area, used for the address reload
	logic hmax;
	logic vmax;

	// syncs, active high inside the design
	logic hs;
	logic vs;

	// visible pixel window
	logic de;

	// start of a 16 pixel slot inside the active area
	logic fetch_start;

	// last pixel of a slot, serializer reload
	logic load;

	modport timing (output vcnt, hmax, vmax, hs, vs, de, fetch_start, load);
	modport fetch (input vcnt, hmax, vmax, fetch_start);
	modport shift (input de, load, hs, vs);

endinterface

// ==== logic/beam_timing.sv ====
/*
 * beam timing generator
 * horizontal and vertical counters with nested wrap
 * sync pulses, display window, fetch and load strobes
 */

`timescale 1ns/1ps

module beam_timing #(
	parameter shifter_pkg::beam_t H_ACT = 10'd640,
	parameter shifter_pkg::beam_t H_FP  = 10'd24,
	parameter shifter_pkg::beam_t H_S   = 10'd40,
	parameter shifter_pkg::beam_t H_BP  = 10'd128,
	parameter shifter_pkg::beam_t V_ACT = 10'd400,
	parameter shifter_pkg::beam_t V_FP  = 10'd55,
	parameter shifter_pkg::beam_t V_S   = 10'd3,
	parameter shifter_pkg::beam_t V_BP  = 10'd73
) (
	input logic     clk,
	input logic     ss,
	beam_if.timing  beam
);
	import shifter_pkg::*;

	localparam beam_t H_TOT    = H_ACT + H_FP + H_S + H_BP;
	localparam beam_t V_TOT    = V_ACT + V_FP + V_S + V_BP;
	// hsync sits behind the prefetch lead like the visible pixels
	localparam beam_t HS_START = H_ACT + H_FP + H_PRE;
	localparam beam_t HS_END   = HS_START + H_S;
	localparam beam_t VS_START = V_ACT + V_FP;
	localparam beam_t VS_END   = VS_START + V_S;
	localparam beam_t DE_END   = H_ACT + H_PRE;

	beam_t hcnt;
	beam_t vcnt;

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			hcnt <= '0;
			vcnt <= '0;
		end else begin
			if (hcnt < H_TOT - 10'd1) begin
				hcnt <= hcnt + 10'd1;
			end else begin
				hcnt <= '0;
				// line done, step the frame
				if (vcnt < V_TOT - 10'd1) begin
					vcnt <= vcnt + 10'd1;
				end else begin
					vcnt <= '0;
				end
			end
		end
	end

	assign beam.vcnt = vcnt;
	assign beam.hs   = (hcnt >= HS_START) && (hcnt < HS_END);
	assign beam.vs   = (vcnt >= VS_START) && (vcnt < VS_END);

	// reload point for the video address
	assign beam.hmax = (hcnt == HS_START);
	assign beam.vmax = (vcnt == VS_START);

	// pixels trail the fetch by one slot
	assign beam.de = (hcnt >= H_PRE) && (hcnt < DE_END) && (vcnt < V_ACT);

	assign beam.fetch_start = (hcnt < H_ACT) && (hcnt[3:0] == 4'd0) && (vcnt < V_ACT);
	assign beam.load        = (hcnt[3:0] == 4'd15);

endmodule

// ==== logic/mono_shifter_top.sv ====
/*
 * mono video shifter top level
 * beam timing, word fetch, serializer and cpu registers
 * memory, register and video as plain ports
 */

`timescale 1ns/1ps

module mono_shifter_top #(
	parameter shifter_pkg::beam_t  H_ACT     = 10'd640,
	parameter shifter_pkg::beam_t  H_FP      = 10'd24,
	parameter shifter_pkg::beam_t  H_S       = 10'd40,
	parameter shifter_pkg::beam_t  H_BP      = 10'd128,
	parameter shifter_pkg::beam_t  V_ACT     = 10'd400,
	parameter shifter_pkg::beam_t  V_FP      = 10'd55,
	parameter shifter_pkg::beam_t  V_S       = 10'd3,
	parameter shifter_pkg::beam_t  V_BP      = 10'd73,
	parameter shifter_pkg::vaddr_t BASE_ADDR = 23'h8000
) (
	input  logic                clk,
	input  logic                ss,
	// cpu register port
	input  logic                reg_sel,
	input  logic                reg_rw,
	input  logic                reg_uds,
	input  logic                reg_lds,
	input  logic [5:0]          reg_addr,
	input  shifter_pkg::word_t  reg_din,
	output shifter_pkg::word_t  reg_dout,
	// screen memory
	output logic                mem_req,
	input  logic                mem_ack,
	input  shifter_pkg::word_t  mem_data,
	output shifter_pkg::vaddr_t vaddr,
	// video out
	output logic                hs_n,
	output logic                vs_n,
	output logic [5:0]          video_r,
	output logic [5:0]          video_g,
	output logic [5:0]          video_b
);
	import shifter_pkg::*;

	vaddr_t base_addr;
	word_t  fetched_word;
	logic   invert;
	logic   pixel;

	beam_if beam ();

	beam_timing #(
		.H_ACT (H_ACT),
		.H_FP  (H_FP),
		.H_S   (H_S),
		.H_BP  (H_BP),
		.V_ACT (V_ACT),
		.V_FP  (V_FP),
		.V_S   (V_S),
		.V_BP  (V_BP)
	) u_timing (
		.clk  (clk),
		.ss   (ss),
		.beam (beam.timing)
	);

	word_fetch u_fetch (
		.clk          (clk),
		.ss           (ss),
		.beam         (beam.fetch),
		.base_addr    (base_addr),
		.mem_req      (mem_req),
		.mem_ack      (mem_ack),
		.mem_data     (mem_data),
		.vaddr        (vaddr),
		.fetched_word (fetched_word)
	);

	pixel_shifter u_shift (
		.clk          (clk),
		.ss           (ss),
		.beam         (beam.shift),
		.fetched_word (fetched_word),
		.invert       (invert),
		.pixel        (pixel),
		.hs_n         (hs_n),
		.vs_n         (vs_n)
	);

	shifter_regs #(
		.BASE_ADDR (BASE_ADDR)
	) u_regs (
		.clk       (clk),
		.ss        (ss),
		.reg_sel   (reg_sel),
		.reg_rw    (reg_rw),
		.reg_uds   (reg_uds),
		.reg_lds   (reg_lds),
		.reg_addr  (reg_addr),
		.reg_din   (reg_din),
		.reg_dout  (reg_dout),
		.vaddr     (vaddr),
		.base_addr (base_addr),
		.invert    (invert)
	);

	// mono pixel on all colour bits
	assign video_r = {6{pixel}};
	assign video_g = {6{pixel}};
	assign video_b = {6{pixel}};

endmodule

// ==== logic/pixel_shifter.sv ====
/*
 * mono output serializer
 * 16 bit shift register, msb first
 * inversion, display gating and active-low syncs
 */

`timescale 1ns/1ps

module pixel_shifter (
	input  logic               clk,
	input  logic               ss,
	beam_if.shift              beam,
	input  shifter_pkg::word_t fetched_word,
	input  logic               invert,
	output logic               pixel,
	output logic               hs_n,
	output logic               vs_n
);
	import shifter_pkg::*;

	// output shift register
	word_t tx;

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			tx <= '0;
		end else if (beam.load) begin
			// word fetched during this slot
			tx <= fetched_word;
		end else begin
			tx <= {tx[14:0], 1'b0};
		end
	end

	// black outside the window
	assign pixel = beam.de & (tx[15] ^ invert);

	// monitor wants negative syncs
	assign hs_n = ~beam.hs;
	assign vs_n = ~beam.vs;

endmodule

// ==== logic/shifter_pkg.sv ====
/*
 * shared types and constants of the mono video shifter
 * word, video address and beam counter widths
 * cpu register address and fetch state enums
 * prefetch lead of the timing generator
 */

package shifter_pkg;

	// one screen memory word, 16 pixels
	typedef logic [15:0] word_t;

	// video word address
	typedef logic [22:0] vaddr_t;

	// horizontal and vertical beam counters
	typedef logic [9:0] beam_t;

	// words are fetched one slot of 16 pixels ahead of display
	localparam beam_t H_PRE = 10'd16;

	// cpu visible registers, 6 bit word address
	typedef enum logic [5:0] {
		REG_BASE_HI   = 6'h00,
		REG_BASE_MID  = 6'h01,
		REG_VADDR_HI  = 6'h02,
		REG_VADDR_MID = 6'h03,
		REG_VADDR_LO  = 6'h04,
		REG_PALETTE0  = 6'h20
	} reg_addr_e;

	// four-phase read handshake
	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_WAIT_ACK,
		FETCH_WAIT_RELEASE
	} fetch_state_e;

endpackage

// ==== logic/shifter_regs.sv ====
/*
 * cpu register block
 * video base address and invert bit with byte lane writes
 * readback of base and live video address
 */

`timescale 1ns/1ps

module shifter_regs #(
	parameter shifter_pkg::vaddr_t BASE_ADDR = 23'h8000
) (
	input  logic                clk,
	input  logic                ss,
	input  logic                reg_sel,
	input  logic                reg_rw,
	input  logic                reg_uds,
	input  logic                reg_lds,
	input  logic [5:0]          reg_addr,
	input  shifter_pkg::word_t  reg_din,
	output shifter_pkg::word_t  reg_dout,
	input  shifter_pkg::vaddr_t vaddr,
	output shifter_pkg::vaddr_t base_addr,
	output logic                invert
);
	import shifter_pkg::*;

	reg_addr_e  addr;
	logic [7:0] base_hi;
	logic [7:0] base_mid;
	word_t      rd_data;

	assign addr = reg_addr_e'(reg_addr);

	// base is always 128 word aligned
	assign base_addr = {base_hi, base_mid, 7'd0};

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			base_hi  <= BASE_ADDR[22:15];
			base_mid <= BASE_ADDR[14:7];
			invert   <= 1'b1;
		end else if (reg_sel && !reg_rw && !reg_lds) begin
			// all fields live in the low byte
			case (addr)
			REG_BASE_HI:  base_hi  <= reg_din[7:0];
			REG_BASE_MID: base_mid <= reg_din[7:0];
			REG_PALETTE0: invert   <= reg_din[0];
			default: ;
			endcase
		end
	end

	always_comb begin
		rd_data = '0;
		case (addr)
		REG_BASE_HI:   rd_data = {8'h00, base_hi};
		REG_BASE_MID:  rd_data = {8'h00, base_mid};
		REG_VADDR_HI:  rd_data = {8'h00, vaddr[22:15]};
		REG_VADDR_MID: rd_data = {8'h00, vaddr[14:7]};
		REG_VADDR_LO:  rd_data = {8'h00, vaddr[6:0], 1'b0};
		REG_PALETTE0:  rd_data = {15'd0, invert};
		default:       rd_data = '0;
		endcase
	end

	// only selected reads drive data, masked per byte lane
	assign reg_dout = (reg_sel && reg_rw) ?
		{rd_data[15:8] & {8{~reg_uds}}, rd_data[7:0] & {8{~reg_lds}}} : 16'h0000;

endmodule

// ==== logic/word_fetch.sv ====
/*
 * screen memory word fetch
 * four-phase req/ack read, one word per 16 pixel slot
 * word latch and video address counter with frame reload
 */

`timescale 1ns/1ps

module word_fetch (
	input  logic                clk,
	input  logic                ss,
	beam_if.fetch               beam,
	input  shifter_pkg::vaddr_t base_addr,
	output logic                mem_req,
	input  logic                mem_ack,
	input  shifter_pkg::word_t  mem_data,
	output shifter_pkg::vaddr_t vaddr,
	output shifter_pkg::word_t  fetched_word
);
	import shifter_pkg::*;

	fetch_state_e state;
	logic         latch;

	// first cycle with ack seen while requesting
	assign latch = (state == FETCH_WAIT_ACK) && mem_ack;

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			state   <= FETCH_IDLE;
			mem_req <= 1'b0;
		end else begin
			case (state)
			FETCH_IDLE: begin
				if (beam.fetch_start) begin
					mem_req <= 1'b1;
					state   <= FETCH_WAIT_ACK;
				end
			end
			FETCH_WAIT_ACK: begin
				// data valid with ack, drop req
				if (mem_ack) begin
					mem_req <= 1'b0;
					state   <= FETCH_WAIT_RELEASE;
				end
			end
			default: begin
				// wait for ack low before the next req
				if (!mem_ack) begin
					mem_req <= beam.fetch_start;
					state   <= beam.fetch_start ? FETCH_WAIT_ACK : FETCH_IDLE;
				end
			end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (latch) begin
			fetched_word <= mem_data;
		end
	end

	// next word on latch, restart from base once per frame
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			vaddr <= base_addr;
		end else if (latch) begin
			vaddr <= vaddr + 23'd1;
		end else if ((state == FETCH_IDLE) && beam.hmax && beam.vmax) begin
			vaddr <= base_addr;
		end
	end

endmodule

// ==== tests/mono_shifter_checker.sv ====
/*
 * concurrent checks on the word fetch handshake
 * bound into the top level beside the word fetch
 */

`timescale 1ns/1ps

module mono_shifter_checker (
	input logic                clk,
	input logic                ss,
	input logic                req,
	input logic                ack,
	input logic                load,
	input shifter_pkg::vaddr_t vaddr
);

	// fetch must be finished before the serializer reloads
	assert property (@(posedge clk) disable iff (ss) load |-> !req)
		else $error("req still high at a load cycle");

	// four-phase rule, ack seen low before req rises again
	assert property (@(posedge clk) disable iff (ss) $rose(req) |-> !$past(ack))
		else $error("req rose while ack was high");

	// address held for the whole request
	assert property (@(posedge clk) disable iff (ss) req && $past(req) |-> $stable(vaddr))
		else $error("vaddr changed while req was high");

	// back-pressure limit of the memory, all four phases done
	assert property (@(posedge clk) disable iff (ss) $rose(req) |-> ##[1:14] (!req && !ack))
		else $error("memory handshake exceeded the cycle limit");

endmodule

bind mono_shifter_top mono_shifter_checker chk (
	.clk   (clk),
	.ss    (ss),
	.req   (mem_req),
	.ack   (mem_ack),
	.load  (beam.load),
	.vaddr (vaddr)
);

// ==== tests/mono_shifter_tb.sv ====
/*
 * testbench of the mono video shifter
 * random register accesses and a random latency memory
 * beam, fetch, pixel and readback model with checks
 */

`timescale 1ns/1ps

module mono_shifter_tb;
	import shifter_pkg::*;

	// small raster
	localparam int H_ACT = 64;
	localparam int H_FP = 8;
	localparam int H_S = 8;
	localparam int H_BP = 16;
	localparam int V_ACT = 8;
	localparam int V_FP = 2;
	localparam int V_S = 1;
	localparam int V_BP = 2;
	localparam int H_TOT = H_ACT + H_FP + H_S + H_BP;
	localparam int V_TOT = V_ACT + V_FP + V_S + V_BP;
	localparam int HS_START = H_ACT + H_FP + int'(H_PRE);
	localparam int VS_START = V_ACT + V_FP;
	localparam int FRAMES = 3;
	localparam int TIMEOUT = 5000;
	localparam vaddr_t BASE = 23'h8000;

	logic clk = 1'b0;
	logic ss = 1'b1;
	logic reg_sel = 1'b0;
	logic reg_rw = 1'b1;
	logic reg_uds = 1'b1;
	logic reg_lds = 1'b1;
	logic [5:0] reg_addr = 6'd0;
	word_t reg_din = '0;
	word_t reg_dout;
	logic mem_req;
	logic mem_ack = 1'b0;
	word_t mem_data = '0;
	vaddr_t vaddr;
	logic hs_n;
	logic vs_n;
	logic [5:0] video_r;
	logic [5:0] video_g;
	logic [5:0] video_b;

	// model state
	int cycles = 0;
	int h;
	int v;
	int wait_cnt;
	int fetch_cnt;
	int idx;
	logic busy;
	logic req_prev;
	logic pix;
	logic [7:0] base_hi;
	logic [7:0] base_mid;
	logic inv;
	vaddr_t exp_addr;
	vaddr_t cur_addr;
	word_t words [4];
	word_t rd;
	logic pend;
	logic [5:0] pend_addr;
	word_t pend_din;
	logic [5:0] pick [7];

	mono_shifter_top #(
		.H_ACT (10'd64), .H_FP (10'd8), .H_S (10'd8), .H_BP (10'd16),
		.V_ACT (10'd8), .V_FP (10'd2), .V_S (10'd1), .V_BP (10'd2),
		.BASE_ADDR (BASE)
	) UUT (
		.clk (clk), .ss (ss),
		.reg_sel (reg_sel), .reg_rw (reg_rw), .reg_uds (reg_uds), .reg_lds (reg_lds),
		.reg_addr (reg_addr), .reg_din (reg_din), .reg_dout (reg_dout),
		.mem_req (mem_req), .mem_ack (mem_ack), .mem_data (mem_data), .vaddr (vaddr),
		.hs_n (hs_n), .vs_n (vs_n),
		.video_r (video_r), .video_g (video_g), .video_b (video_b)
	);

	always #2 clk = ~clk;

	// hard limit on the run length
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("timeout: no end of test after %0d cycles", TIMEOUT);
			$display("STATUS: FAIL");
			$fatal(1, "timeout");
		end
	end

	task automatic compare(input logic [31:0] act, input logic [31:0] exp, input string what);
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, what, act, exp);
			$display("STATUS: FAIL");
			$fatal(1, "check failed");
		end
	endtask

	// screen memory content
	function automatic word_t scramble(input vaddr_t a);
		return a[15:0] ^ {a[7:0], a[22:15]} ^ 16'ha5c3;
	endfunction

	initial begin
		void'($urandom(66268));
		pick = '{6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h20, 6'h11};
		h = 0;
		v = 0;
		busy = 1'b0;
		wait_cnt = 0;
		fetch_cnt = 0;
		req_prev = 1'b0;
		base_hi = BASE[22:15];
		base_mid = BASE[14:7];
		inv = 1'b1;
		exp_addr = BASE;
		pend = 1'b0;
		pend_addr = '0;
		pend_din = '0;
		for (idx = 0; idx < 4; idx++) begin
			words[idx] = '0;
		end
		repeat (5) @(posedge clk);
		#1 ss = 1'b0;

		repeat (FRAMES * H_TOT * V_TOT) begin
			@(posedge clk);
			// beam counters and register writes of the last cycle
			h = h + 1;
			if (h == H_TOT) begin
				h = 0;
				v = (v == V_TOT - 1) ? 0 : v + 1;
			end
			if (pend) begin
				case (pend_addr)
				6'h00: base_hi = pend_din[7:0];
				6'h01: base_mid = pend_din[7:0];
				6'h20: inv = pend_din[0];
				default: ;
				endcase
				pend = 1'b0;
			end
			#1;
			// memory with 1 to 4 cycles of latency
			if (mem_ack && !mem_req) begin
				mem_ack = 1'b0;
			end else if (mem_req && !mem_ack) begin
				if (!busy) begin
					busy = 1'b1;
					wait_cnt = $urandom_range(1, 4);
				end
				wait_cnt = wait_cnt - 1;
				if (wait_cnt == 0) begin
					busy = 1'b0;
					mem_ack = 1'b1;
					mem_data = scramble(vaddr);
					words[h >> 4] = mem_data;
				end
			end
			// random cpu access
			reg_sel = ($urandom_range(0, 3) == 0);
			reg_rw = 1'($urandom_range(0, 1));
			reg_uds = 1'($urandom_range(0, 1));
			reg_lds = 1'($urandom_range(0, 1));
			reg_addr = pick[$urandom_range(0, 6)];
			reg_din = 16'($urandom);
			if (reg_sel && !reg_rw && !reg_lds) begin
				pend = 1'b1;
				pend_addr = reg_addr;
				pend_din = reg_din;
			end
			#1;
			// new request, address follows the model
			if (mem_req && !req_prev) begin
				compare(32'(vaddr), 32'(exp_addr), "request address");
				exp_addr = exp_addr + 23'd1;
				fetch_cnt = fetch_cnt + 1;
			end
			req_prev = mem_req;
			// vaddr lags the model by one while a request is open
			cur_addr = mem_req ? exp_addr - 23'd1 : exp_addr;
			compare(32'(hs_n), 32'(!(h >= HS_START && h < HS_START + H_S)), "hs_n");
			compare(32'(vs_n), 32'(!(v >= VS_START && v < VS_START + V_S)), "vs_n");
			// pixel at hcnt 16k+16+j is bit 15-j of word k
			pix = 1'b0;
			if (h >= int'(H_PRE) && h < H_ACT + int'(H_PRE) && v < V_ACT) begin
				pix = words[(h - 16) >> 4][15 - ((h - 16) & 15)] ^ inv;
			end
			compare(32'(video_r), 32'({6{pix}}), "video_r");
			compare(32'(video_g), 32'({6{pix}}), "video_g");
			compare(32'(video_b), 32'({6{pix}}), "video_b");
			// readback with byte lane masks
			rd = '0;
			case (reg_addr)
			6'h00: rd = {8'h00, base_hi};
			6'h01: rd = {8'h00, base_mid};
			6'h02: rd = {8'h00, cur_addr[22:15]};
			6'h03: rd = {8'h00, cur_addr[14:7]};
			6'h04: rd = {8'h00, cur_addr[6:0], 1'b0};
			6'h20: rd = {15'd0, inv};
			default: rd = '0;
			endcase
			if (!(reg_sel && reg_rw)) begin
				rd = '0;
			end
			if (reg_uds) begin
				rd[15:8] = 8'h00;
			end
			if (reg_lds) begin
				rd[7:0] = 8'h00;
			end
			compare(32'(reg_dout), 32'(rd), "register readback");
			// end of frame, reload from the base in effect now
			if (h == HS_START && v == VS_START) begin
				compare(32'(fetch_cnt), 32'(H_ACT / 16 * V_ACT), "fetches per frame");
				fetch_cnt = 0;
				exp_addr = {base_hi, base_mid, 7'd0};
			end
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule
